/* design/viterbi_pkg.sv */
package viterbi_pkg;

        localparam int NUM_BEAMS   = 3;
        localparam int NUM_SYMBOLS = 8;
        localparam int SYM_W       = 3;
        localparam int CODE_W      = 4;
        localparam int MAX_LEN     = 16;
        localparam int SEQ_W       = MAX_LEN * CODE_W;
        localparam int PROB_W      = 8;
        localparam int TRANS_W     = 8;
        localparam int SCORE_W     = 24;
        localparam int NORM_SHIFT  = 16;
        localparam int START_ROW   = 8;
        localparam int TRANS_DEPTH = (NUM_SYMBOLS + 1) * NUM_SYMBOLS;
        localparam int LEN_W       = 5;

        localparam string TRANS_FILE = "design/transition.hex";

        typedef logic [SYM_W-1:0]   sym_t;
        typedef logic [PROB_W-1:0]  prob_t;
        typedef logic [SCORE_W-1:0] score_t;
        typedef logic [SEQ_W-1:0]   seq_t;

        // row 8 holds the start probabilities.
        function automatic int unsigned trans_index(input int unsigned row, input sym_t sym);
                return row * NUM_SYMBOLS + sym;
        endfunction

        function automatic logic [CODE_W-1:0] sym_code(input sym_t sym);
                return CODE_W'(sym) + 1'b1;
        endfunction

        function automatic score_t start_score(input prob_t prob,
                                               input logic [TRANS_W-1:0] trans);
                logic [PROB_W+TRANS_W-1:0] prod;
                prod = prob * trans;
                return score_t'(prod);
        endfunction

        // product is renormalised so it fits the score width again.
        function automatic score_t ext_score(input score_t score, input prob_t prob,
                                             input logic [TRANS_W-1:0] trans);
                logic [SCORE_W+PROB_W+TRANS_W-1:0] prod;
                prod = score * prob * trans;
                return score_t'(prod >> NORM_SHIFT);
        endfunction

        // oldest code drops out at the top.
        function automatic seq_t push_code(input seq_t seq, input sym_t sym);
                return {seq[SEQ_W-CODE_W-1:0], sym_code(sym)};
        endfunction

        // a strict compare lets the lowest index win a tie.
        function automatic int unsigned best_index(input score_t scores [NUM_BEAMS]);
                int unsigned best;
                best = 0;
                for (int k = 1; k < NUM_BEAMS; k++) begin
                        if (scores[k] > scores[best]) begin
                                best = k;
                        end
                end
                return best;
        endfunction

endpackage

/* design/viterbi_if.sv */
`timescale 1ns/1ps

// carries survivors and step control from the bank to the branch units and the selector.
interface survivor_if import viterbi_pkg::*; ();

        logic   req;
        logic   init;
        score_t surv_score [NUM_BEAMS];
        seq_t   surv_seq   [NUM_BEAMS];
        sym_t   surv_last  [NUM_BEAMS];
        logic   updated;

        modport source (
                output req,
                output init,
                output surv_score,
                output surv_seq,
                output surv_last,
                output updated
        );

        modport sink (
                input req,
                input init,
                input surv_score,
                input surv_seq,
                input surv_last,
                input updated
        );

endinterface

// carries one branch result back to the bank.
interface branch_if import viterbi_pkg::*; ();

        logic   valid;
        score_t score;
        seq_t   seq;
        sym_t   last;

        modport source (
                output valid,
                output score,
                output seq,
                output last
        );

        modport sink (
                input valid,
                input score,
                input seq,
                input last
        );

endinterface

/* design/survivor_bank.sv */
`timescale 1ns/1ps

module survivor_bank import viterbi_pkg::*; (
        input  logic             i_clk,
        input  logic             i_rst_n,
        input  logic             i_start,
        input  logic             i_next,
        survivor_if.source       surv,
        branch_if.sink           br [NUM_BEAMS],
        output logic [LEN_W-1:0] o_len
);

        logic                 busy;
        logic                 init_pend;
        logic                 accept;
        logic                 load;
        logic [NUM_BEAMS-1:0] br_valid;
        score_t               br_score [NUM_BEAMS];
        seq_t                 br_seq   [NUM_BEAMS];
        sym_t                 br_last  [NUM_BEAMS];

        // interface arrays only take constant indices.
        for (genvar b = 0; b < NUM_BEAMS; b++) begin : g_gather
                assign br_valid[b] = br[b].valid;
                assign br_score[b] = br[b].score;
                assign br_seq[b]   = br[b].seq;
                assign br_last[b]  = br[b].last;
        end

        // one step in flight; start takes priority over next.
        assign accept    = (i_start | i_next) & ~busy;
        assign load      = &br_valid;
        assign surv.req  = accept;
        assign surv.init = i_start;

        always_ff @(posedge i_clk or posedge i_rst_n) begin
                if (i_rst_n) begin
                        busy      <= 1'b0;
                        init_pend <= 1'b0;
                end else if (accept) begin
                        busy      <= 1'b1;
                        init_pend <= i_start;
                end else if (surv.updated) begin
                        busy <= 1'b0;
                end
        end

        always_ff @(posedge i_clk or posedge i_rst_n) begin
                if (i_rst_n) begin
                        surv.updated <= 1'b0;
                end else begin
                        surv.updated <= load;
                end
        end

        always_ff @(posedge i_clk or posedge i_rst_n) begin
                if (i_rst_n) begin
                        for (int k = 0; k < NUM_BEAMS; k++) begin
                                surv.surv_score[k] <= '0;
                                surv.surv_seq[k]   <= '0;
                                surv.surv_last[k]  <= '0;
                        end
                end else if (load) begin
                        for (int k = 0; k < NUM_BEAMS; k++) begin
                                surv.surv_score[k] <= br_score[k];
                                surv.surv_seq[k]   <= br_seq[k];
                                surv.surv_last[k]  <= br_last[k];
                        end
                end
        end

        // counts decoded symbols, saturating at a full sequence.
        always_ff @(posedge i_clk or posedge i_rst_n) begin
                if (i_rst_n) begin
                        o_len <= '0;
                end else if (load) begin
                        if (init_pend) begin
                                o_len <= LEN_W'(1);
                        end else if (o_len != LEN_W'(MAX_LEN)) begin
                                o_len <= o_len + 1'b1;
                        end
                end
        end

endmodule

/* design/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit import viterbi_pkg::*; (
        input  logic       i_clk,
        input  logic       i_rst_n,
        input  sym_t       i_char,
        input  prob_t      i_prob,
        survivor_if.sink   surv,
        branch_if.source   br
);

        logic [TRANS_W-1:0] trans_mem [TRANS_DEPTH];

        score_t      ext [NUM_BEAMS];
        int unsigned best;
        score_t      nxt_score;
        seq_t        nxt_seq;

        initial begin
                $readmemh(TRANS_FILE, trans_mem);
        end

        // extension of every survivor by this candidate.
        always_comb begin
                for (int k = 0; k < NUM_BEAMS; k++) begin
                        ext[k] = ext_score(surv.surv_score[k], i_prob,
                                           trans_mem[trans_index(surv.surv_last[k], i_char)]);
                end
                best = best_index(ext);
        end

        always_comb begin
                if (surv.init) begin
                        nxt_score = start_score(i_prob,
                                                trans_mem[trans_index(START_ROW, i_char)]);
                        nxt_seq   = SEQ_W'(sym_code(i_char));
                end else begin
                        nxt_score = ext[best];
                        nxt_seq   = push_code(surv.surv_seq[best], i_char);
                end
        end

        always_ff @(posedge i_clk or posedge i_rst_n) begin
                if (i_rst_n) begin
                        br.valid <= 1'b0;
                end else begin
                        br.valid <= surv.req;
                end
        end

        // observations are only valid in the cycle of req.
        always_ff @(posedge i_clk) begin
                if (surv.req) begin
                        br.score <= nxt_score;
                        br.seq   <= nxt_seq;
                        br.last  <= i_char;
                end
        end

endmodule

/* design/best_path_select.sv */
`timescale 1ns/1ps

module best_path_select import viterbi_pkg::*; (
        input  logic             i_clk,
        input  logic             i_rst_n,
        survivor_if.sink         surv,
        input  logic [LEN_W-1:0] i_len,
        output seq_t             o_seq,
        output logic             o_stepped,
        output logic             o_finished
);

        int unsigned best;

        always_comb begin
                best = best_index(surv.surv_score);
        end

        always_ff @(posedge i_clk or posedge i_rst_n) begin
                if (i_rst_n) begin
                        o_stepped <= 1'b0;
                end else begin
                        o_stepped <= surv.updated;
                end
        end

        // length already reflects this step when updated is high.
        always_ff @(posedge i_clk or posedge i_rst_n) begin
                if (i_rst_n) begin
                        o_seq      <= '0;
                        o_finished <= 1'b0;
                end else if (surv.updated) begin
                        o_seq      <= surv.surv_seq[best];
                        o_finished <= (i_len == LEN_W'(MAX_LEN));
                end
        end

endmodule

/* design/viterbi_top.sv */
`timescale 1ns/1ps

module viterbi_top import viterbi_pkg::*; (
        input  logic  i_clk,
        input  logic  i_rst_n,
        input  logic  i_start,
        input  logic  i_next,
        input  prob_t i_prob [NUM_BEAMS],
        input  sym_t  i_char [NUM_BEAMS],
        output seq_t  o_seq,
        output logic  o_stepped,
        output logic  o_finished
);

        logic [LEN_W-1:0] len;

        survivor_if u_surv_if ();
        branch_if   u_br_if [NUM_BEAMS] ();

        survivor_bank u_survivor_bank (
                .i_clk   (i_clk),
                .i_rst_n (i_rst_n),
                .i_start (i_start),
                .i_next  (i_next),
                .surv    (u_surv_if),
                .br      (u_br_if),
                .o_len   (len)
        );

        // one branch unit per candidate.
        for (genvar g = 0; g < NUM_BEAMS; g++) begin : g_branch
                branch_unit u_branch_unit (
                        .i_clk   (i_clk),
                        .i_rst_n (i_rst_n),
                        .i_char  (i_char[g]),
                        .i_prob  (i_prob[g]),
                        .surv    (u_surv_if),
                        .br      (u_br_if[g])
                );
        end

        best_path_select u_best_path_select (
                .i_clk      (i_clk),
                .i_rst_n    (i_rst_n),
                .surv       (u_surv_if),
                .i_len      (len),
                .o_seq      (o_seq),
                .o_stepped  (o_stepped),
                .o_finished (o_finished)
        );

endmodule

/* verification/viterbi_model.svh */
`ifndef VITERBI_MODEL_SVH
`define VITERBI_MODEL_SVH

        logic [TRANS_W-1:0] model_trans [TRANS_DEPTH];
        score_t             model_score [NUM_BEAMS];
        seq_t               model_seq   [NUM_BEAMS];
        sym_t               model_last  [NUM_BEAMS];
        int                 model_len;
        logic [31:0]        rng_state;

        task automatic load_table();
                $readmemh(TRANS_FILE, model_trans);
        endtask

        function automatic logic [31:0] lcg_next();
                rng_state = rng_state * 32'd1664525 + 32'd1013904223;
                return rng_state;
        endfunction

        task automatic model_reset();
                for (int k = 0; k < NUM_BEAMS; k++) begin
                        model_score[k] = '0;
                        model_seq[k]   = '0;
                        model_last[k]  = '0;
                end
                model_len = 0;
        endtask

        // one decoding step on the model survivors that returns the expected outputs.
        function automatic void model_step(input bit init,
                                           input logic [NUM_BEAMS*SYM_W-1:0] chars,
                                           input logic [NUM_BEAMS*PROB_W-1:0] probs,
                                           output seq_t exp_seq, output bit exp_fin);
                score_t          new_score [NUM_BEAMS];
                seq_t            new_seq   [NUM_BEAMS];
                longint unsigned prod;
                longint unsigned best_prod;
                int              best_k;
                int              row;
                int              win;
                int              ch;
                int              pr;
                for (int j = 0; j < NUM_BEAMS; j++) begin
                        ch = chars[j*SYM_W +: SYM_W];
                        pr = probs[j*PROB_W +: PROB_W];
                        if (init) begin
                                prod         = pr * model_trans[START_ROW * NUM_SYMBOLS + ch];
                                new_score[j] = prod[SCORE_W-1:0];
                                new_seq[j]   = ch + 1;
                        end else begin
                                best_prod = 0;
                                best_k    = 0;
                                for (int k = 0; k < NUM_BEAMS; k++) begin
                                        row  = model_last[k];
                                        prod = model_score[k];
                                        prod = prod * pr * model_trans[row * NUM_SYMBOLS + ch];
                                        prod = (prod >> NORM_SHIFT) & 64'hff_ffff;
                                        if (k == 0 || prod > best_prod) begin
                                                best_prod = prod;
                                                best_k    = k;
                                        end
                                end
                                new_score[j] = best_prod[SCORE_W-1:0];
                                new_seq[j]   = (model_seq[best_k] << CODE_W) | (ch + 1);
                        end
                end
                for (int j = 0; j < NUM_BEAMS; j++) begin
                        model_score[j] = new_score[j];
                        model_seq[j]   = new_seq[j];
                        model_last[j]  = chars[j*SYM_W +: SYM_W];
                end
                if (init) begin
                        model_len = 1;
                end else if (model_len < MAX_LEN) begin
                        model_len = model_len + 1;
                end
                win = 0;
                for (int k = 1; k < NUM_BEAMS; k++) begin
                        if (model_score[k] > model_score[win]) begin
                                win = k;
                        end
                end
                exp_seq = model_seq[win];
                exp_fin = (model_len == MAX_LEN);
        endfunction

`endif

/* verification/viterbi_tb.sv */
`timescale 1ns/1ps

module viterbi_tb import viterbi_pkg::*; ();

        localparam int STEP_TIMEOUT = 32;

        logic  i_clk;
        logic  i_rst_n;
        logic  i_start;
        logic  i_next;
        prob_t i_prob [NUM_BEAMS];
        sym_t  i_char [NUM_BEAMS];
        seq_t  o_seq;
        logic  o_stepped;
        logic  o_finished;

        seq_t exp_seq_q [$];
        bit   exp_fin_q [$];
        int   n_issued;
        int   n_checked;

        `include "viterbi_model.svh"

        viterbi_top u_viterbi_top (
                .i_clk      (i_clk),
                .i_rst_n    (i_rst_n),
                .i_start    (i_start),
                .i_next     (i_next),
                .i_prob     (i_prob),
                .i_char     (i_char),
                .o_seq      (o_seq),
                .o_stepped  (o_stepped),
                .o_finished (o_finished)
        );

        always #50 i_clk = ~i_clk;

        task automatic stop_with_failure(input string why);
                $display("%s", why);
                $display("TESTS FAILED");
                $fatal(1, "simulation stopped");
        endtask

        task automatic check_value(input string name, input logic [SEQ_W-1:0] got,
                                   input logic [SEQ_W-1:0] exp);
                if (got !== exp) begin
                        stop_with_failure($sformatf("FAIL %s got 0x%0h expected 0x%0h",
                                                    name, got, exp));
                end
        endtask

        task automatic drive_junk();
                logic [31:0] rnd;
                for (int j = 0; j < NUM_BEAMS; j++) begin
                        rnd = lcg_next();
                        i_char[j] <= rnd[29:27];
                        i_prob[j] <= rnd[23:16];
                end
        endtask

        task automatic run_step(input bit start, input bit next, input bit noise);
                logic [NUM_BEAMS*SYM_W-1:0]  chars;
                logic [NUM_BEAMS*PROB_W-1:0] probs;
                logic [31:0]                 rnd;
                seq_t                        exp_seq;
                bit                          exp_fin;
                int                          waited;
                for (int j = 0; j < NUM_BEAMS; j++) begin
                        rnd = lcg_next();
                        chars[j*SYM_W +: SYM_W]   = rnd[26:24];
                        probs[j*PROB_W +: PROB_W] = {1'b1, rnd[22:16]};
                end
                model_step(start, chars, probs, exp_seq, exp_fin);
                exp_seq_q.push_back(exp_seq);
                exp_fin_q.push_back(exp_fin);
                n_issued++;
                @(posedge i_clk);
                i_start <= start;
                i_next  <= next;
                for (int j = 0; j < NUM_BEAMS; j++) begin
                        i_char[j] <= chars[j*SYM_W +: SYM_W];
                        i_prob[j] <= probs[j*PROB_W +: PROB_W];
                end
                @(posedge i_clk);
                i_start <= 1'b0;
                i_next  <= noise;
                // the bank has to drop strobes that come while busy.
                if (noise) begin
                        drive_junk();
                        @(posedge i_clk);
                        drive_junk();
                        @(posedge i_clk);
                        i_next <= 1'b0;
                end
                waited = 0;
                while (n_checked < n_issued) begin
                        @(posedge i_clk);
                        waited++;
                        if (waited > STEP_TIMEOUT) begin
                                stop_with_failure("timeout waiting for a step to be checked");
                        end
                end
        endtask

        initial begin : compare
                int   waited;
                seq_t exp_seq;
                bit   exp_fin;
                waited = 0;
                forever begin
                        @(negedge i_clk);
                        if (exp_seq_q.size() != 0 && o_stepped !== 1'b1) begin
                                waited++;
                                if (waited > STEP_TIMEOUT) begin
                                        stop_with_failure("timeout, no o_stepped for an issued step");
                                end
                        end
                        if (o_stepped === 1'b1) begin
                                if (exp_seq_q.size() == 0) begin
                                        stop_with_failure("o_stepped pulsed with no step issued");
                                end else begin
                                        exp_seq = exp_seq_q.pop_front();
                                        exp_fin = exp_fin_q.pop_front();
                                        check_value("o_seq", o_seq, exp_seq);
                                        check_value("o_finished", SEQ_W'(o_finished),
                                                    SEQ_W'(exp_fin));
                                        @(negedge i_clk);
                                        check_value("o_stepped", SEQ_W'(o_stepped), '0);
                                        waited = 0;
                                        n_checked++;
                                end
                        end
                end
        end

        initial begin : stimulus
                i_clk     = 1'b0;
                i_rst_n   = 1'b1;
                i_start   = 1'b0;
                i_next    = 1'b0;
                for (int j = 0; j < NUM_BEAMS; j++) begin
                        i_char[j] = '0;
                        i_prob[j] = '0;
                end
                rng_state = 32'h82f18567;
                n_issued  = 0;
                n_checked = 0;
                load_table();
                model_reset();
                repeat (16) @(posedge i_clk);
                i_rst_n <= 1'b0;
                @(negedge i_clk);
                check_value("o_seq", o_seq, '0);
                check_value("o_stepped", SEQ_W'(o_stepped), '0);
                check_value("o_finished", SEQ_W'(o_finished), '0);

                run_step(1'b1, 1'b0, 1'b0);
                for (int s = 1; s < 8; s++) begin
                        run_step(1'b0, 1'b1, s % 3 == 1);
                end
                // start has priority when both strobes are high.
                run_step(1'b1, 1'b1, 1'b0);
                for (int s = 1; s < 20; s++) begin
                        run_step(1'b0, 1'b1, s % 4 == 2);
                end
                run_step(1'b1, 1'b0, 1'b1);
                for (int s = 1; s < 4; s++) begin
                        run_step(1'b0, 1'b1, s % 2 == 1);
                end
                // a wrongly accepted strobe would show up as an extra step here.
                repeat (4) @(posedge i_clk);
                $display("TESTS PASSED");
                $finish;
        end

endmodule

/* all.f */
+incdir+verification
design/viterbi_pkg.sv
design/viterbi_if.sv
design/survivor_bank.sv
design/branch_unit.sv
design/best_path_select.sv
design/viterbi_top.sv
verification/viterbi_tb.sv

/* Bender.yml */
package:
  name: viterbi_decoder

sources:
  - design/viterbi_pkg.sv
  - design/viterbi_if.sv
  - design/survivor_bank.sv
  - design/branch_unit.sv
  - design/best_path_select.sv
  - design/viterbi_top.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/viterbi_tb.sv

/* design/transition.hex */
// one row per predecessor symbol 0 to 7 and then the start row, one column per new symbol.
c8 9a f0 64 b4 dc 7d e6
a0 f5 88 d2 6e bc fa 93
e1 72 c3 ff 96 a8 5a d7
8c e9 b0 7a f8 65 cd 9e
f2 84 d9 a6 70 ee 99 bb
6b c6 a3 ea 90 f7 82 d0
b7 fc 78 95 de 8a e4 69
9d ab ec 80 c9 74 f3 b2
d4 a5 f9 8e c0 b6 e8 97
